// File: sim.f
design/genie_map_pkg.sv
design/genie_port_pkg.sv
design/genie_bus_if.sv
design/bus_decoder.sv
design/io_ports.sv
design/mem_map.sv
design/genie_sys.sv
test/tb_genie_sys.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass message
verilator --binary --timing --assert -f sim.f --top-module tb_genie_sys -Mdir obj_dir \
  >/dev/null || { echo "build error"; exit 1; }
out=$(./obj_dir/Vtb_genie_sys 2>&1)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx 'sim passed' && echo "run ok" || { echo "run bad"; exit 1; }

// File: test/tb_genie_sys.sv
/*
  directed testbench for the processor side top level. wishbone tasks
  stand in for the cpu, a function models the external rom
*/
`timescale 1ns/1ps
`default_nettype none

module tb_genie_sys;
  import genie_map_pkg::*;
  import genie_port_pkg::*;

  localparam int CLK_NS      = 4;
  localparam int EST_XFERS   = 2200;                     // ram test dominates
  localparam int WATCHDOG_NS = 40 * EST_XFERS * 4 * CLK_NS;  // about 4 cycles a transfer

  logic              w_clk_cpu = 1'b0;
  logic              w_cpu_reset;
  logic              i_wb_cyc, i_wb_stb, i_wb_we, o_wb_ack;
  logic [ADDR_W-1:0] i_wb_adr;
  logic [DATA_W-1:0] i_wb_dat, o_wb_dat, i_rom_data;
  logic              i_m1, i_key_press, i_hblank, i_vblank, o_nmi;
  logic [6:0]        i_kbd_code;
  logic [ROM_AW-1:0] o_rom_addr;
  logic [ROM_AW-1:0] rom_addr_seen;  // rom address at the last ack
  int                errors = 0;
  int                checks = 0;
  int                tests  = 0;

  always #(CLK_NS/2) w_clk_cpu = ~w_clk_cpu;

  // rom contents, low byte folded with the upper address bits
  function automatic logic [DATA_W-1:0] rom_lookup(input logic [ROM_AW-1:0] a);
    return a[7:0] ^ {3'b000, a[12:8]};
  endfunction

  assign i_rom_data = rom_lookup(o_rom_addr);  // combinational rom

  genie_sys #(.RAM_AW(16), .VRAM_AW(11)) u_genie_sys (.*);

  task automatic step_cycle();
    @(posedge w_clk_cpu);
    #1;  // drive just after the edge
  endtask

  // classic cycle held until ack, then stb low across one edge
  task automatic wb_transfer(input logic we, input logic [ADDR_W-1:0] adr,
                             input logic [DATA_W-1:0] wdat, output logic [DATA_W-1:0] rdat);
    i_wb_cyc = 1'b1;
    i_wb_stb = 1'b1;
    i_wb_we  = we;
    i_wb_adr = adr;
    i_wb_dat = wdat;
    @(negedge w_clk_cpu);
    while (!o_wb_ack) @(negedge w_clk_cpu);  // watchdog covers a missing ack
    rdat = o_wb_dat;                         // read data valid with ack
    rom_addr_seen = o_rom_addr;
    step_cycle();
    i_wb_cyc = 1'b0;
    i_wb_stb = 1'b0;
    i_wb_we  = 1'b0;
    step_cycle();
  endtask

  task automatic wb_write(input logic [ADDR_W-1:0] adr, input logic [DATA_W-1:0] wdat);
    logic [DATA_W-1:0] ignored;
    wb_transfer(1'b1, adr, wdat, ignored);
  endtask

  task automatic wb_read(input logic [ADDR_W-1:0] adr, output logic [DATA_W-1:0] rdat);
    wb_transfer(1'b0, adr, '0, rdat);
  endtask

  task automatic write_ctrl(input logic [DATA_W-1:0] val);
    wb_write({PORT_PAGE_HI, PORT_CTRL}, val);
  endtask

  task automatic check_data(input string name, input logic [DATA_W-1:0] exp,
                            input logic [DATA_W-1:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s: expected %02h, actual %02h", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s: expected %0b, actual %0b", name, exp, act);
    end
  endtask

  task automatic check_rom_addr(input string name, input logic [ROM_AW-1:0] exp,
                                input logic [ROM_AW-1:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s: expected %04h, actual %04h", name, exp, act);
    end
  endtask

  task automatic read_expect(input string name, input logic [ADDR_W-1:0] adr,
                             input logic [DATA_W-1:0] exp);
    logic [DATA_W-1:0] rd;
    wb_read(adr, rd);
    check_data(name, exp, rd);
  endtask

  // rom read, checks the translated address and the returned byte
  task automatic rom_expect(input string name, input logic [ADDR_W-1:0] adr,
                            input logic [ROM_AW-1:0] rom_adr);
    read_expect(name, adr, rom_lookup(rom_adr));
    check_rom_addr(name, rom_adr, rom_addr_seen);
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests++;
    $display("test %-10s %s (%0d errors)", name,
             errors == errs_before ? "ok" : "bad", errors - errs_before);
  endtask

  // runs in the low map, straight after reset
  task automatic test_rom_remap();
    int e0;
    e0 = errors;
    rom_expect("rom E123", 16'hE123, 13'h0123);  // low 12 bits
    rom_expect("rom F7AB", 16'hF7AB, 13'h11AB);  // a12, 00, a11, a8..a0
    rom_expect("rom 1C55", 16'h1C55, 13'h1455);  // a12, 0, a10..a0
    rom_expect("unmapped", 16'h8ABC, 13'h0ABC);  // plain low 13 bits
    report_test("rom_remap", e0);
  endtask

  task automatic test_ports();
    logic [DATA_W-1:0] rd;
    int e0;
    e0 = errors;
    for (int i = 0; i < 4; i++) begin
      i_hblank = i[1];
      i_vblank = i[0];
      read_expect("status A", {PORT_PAGE_HI, PORT_STATUS_A}, {6'h3F, ~i[1], ~i[0]});
      read_expect("status B", {PORT_PAGE_HI, PORT_STATUS_B}, {i[1], i[0], 6'h00});
    end
    i_hblank    = 1'b0;
    i_vblank    = 1'b0;
    i_kbd_code  = 7'h5A;
    i_key_press = 1'b1;                     // single cycle press
    step_cycle();
    i_key_press = 1'b0;
    wb_read({PORT_PAGE_HI, PORT_STATUS_B}, rd);
    check_flag("key ready", 1'b1, rd[0]);
    read_expect("key code", {PORT_PAGE_HI, PORT_CTRL}, {1'b0, 7'h5A});
    read_expect("alias FE", {PORT_ALIAS_HI, PORT_STATUS_B}, 8'h01);
    write_ctrl(8'h00);                      // bit 0 low acknowledges the key
    wb_read({PORT_PAGE_HI, PORT_STATUS_B}, rd);
    check_flag("key clear", 1'b0, rd[0]);
    write_ctrl(8'h80);                      // high map, 1Bxx turns into ram
    wb_write(16'h1BFE, 8'hA5);
    read_expect("alias off", 16'h1BFE, 8'hA5);
    write_ctrl(8'h00);
    read_expect("alias on", 16'h1BFE, 8'h00);  // status B again, all quiet
    report_test("ports", e0);
  endtask

  task automatic test_video();
    logic [DATA_W-1:0] v [4];
    int e0;
    e0 = errors;
    foreach (v[i]) v[i] = DATA_W'($urandom);
    write_ctrl(8'h00);                      // video ram
    wb_write(16'hF123, v[0]);
    wb_write(16'hF5FF, v[1]);
    write_ctrl(8'h40);                      // attribute ram
    wb_write(16'hF123, v[2]);
    wb_write(16'hF5FF, v[3]);
    read_expect("attr F123", 16'hF123, v[2]);
    read_expect("attr F5FF", 16'hF5FF, v[3]);
    write_ctrl(8'h00);
    read_expect("vram F123", 16'hF123, v[0]);
    read_expect("vram F5FF", 16'hF5FF, v[1]);
    report_test("video", e0);
  endtask

  task automatic pulse_m1();
    i_m1 = 1'b1;
    step_cycle();
    i_m1 = 1'b0;
    step_cycle();
  endtask

  task automatic test_nmi();
    int e0;
    e0 = errors;
    write_ctrl(8'h02);                      // start from an empty counter
    write_ctrl(8'h00);
    for (int n = 1; n <= 8; n++) begin
      pulse_m1();
      check_flag("nmi count", n == 8, o_nmi);  // rises on the 8th fetch
    end
    write_ctrl(8'h02);
    check_flag("nmi clear", 1'b0, o_nmi);
    for (int n = 0; n < 8; n++)
      pulse_m1();
    check_flag("nmi held", 1'b0, o_nmi);    // bit 1 high stops counting
    write_ctrl(8'h00);
    report_test("nmi", e0);
  endtask

  task automatic test_ram();
    logic [DATA_W-1:0] top [0:1023];
    logic [ADDR_W-1:0] probe [5] = '{16'h0000, 16'h1B00, 16'h1C55, 16'h9ABC, 16'hDFFF};
    logic [DATA_W-1:0] pv [5];
    logic [DATA_W-1:0] v;
    int e0;
    e0 = errors;
    for (int i = 0; i < 1024; i++) begin
      top[i] = DATA_W'($urandom);
      wb_write(RAM_TOP_LO + ADDR_W'(i), top[i]);
    end
    for (int i = 0; i < 1024; i++)
      read_expect("ram top", RAM_TOP_LO + ADDR_W'(i), top[i]);
    v = DATA_W'($urandom);
    wb_write(16'h4005, v);                  // low window lands on 0005
    write_ctrl(8'h80);
    read_expect("ram fold", 16'h0005, v);
    foreach (probe[i]) begin
      pv[i] = DATA_W'($urandom);
      wb_write(probe[i], pv[i]);
    end
    foreach (probe[i])
      read_expect("ram high", probe[i], pv[i]);
    write_ctrl(8'h00);                      // back to the low map
    report_test("ram", e0);
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("run timed out after %0d ns, the bus stopped answering", WATCHDOG_NS);
    $display("sim failed");
    $finish;
  end

  initial begin
    int unsigned seed;
    w_cpu_reset = 1'b0;
    i_wb_cyc    = 1'b0;
    i_wb_stb    = 1'b0;
    i_wb_we     = 1'b0;
    i_wb_adr    = '0;
    i_wb_dat    = '0;
    i_m1        = 1'b0;
    i_key_press = 1'b0;
    i_kbd_code  = '0;
    i_hblank    = 1'b0;
    i_vblank    = 1'b0;
    seed = $urandom(32'h2a7a_598e);         // one seed for the whole run
    repeat (5) @(posedge w_clk_cpu);
    #1;
    w_cpu_reset = 1'b1;
    step_cycle();
    test_rom_remap();
    test_ports();
    test_video();
    test_nmi();
    test_ram();
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: design/genie_sys.sv
/*
  processor side top level. a wishbone master stands in for the cpu,
  the rom sits outside and is reached through o_rom_addr and i_rom_data
*/
`timescale 1ns/1ps
`default_nettype none

module genie_sys #(
  parameter int RAM_AW  = 16,
  parameter int VRAM_AW = 11
) (
  input  logic                               w_clk_cpu,
  input  logic                               w_cpu_reset,    // async, active low
  input  logic                               i_wb_cyc,
  input  logic                               i_wb_stb,
  input  logic                               i_wb_we,
  input  logic [genie_map_pkg::ADDR_W-1:0]   i_wb_adr,
  input  logic [genie_map_pkg::DATA_W-1:0]   i_wb_dat,
  output logic [genie_map_pkg::DATA_W-1:0]   o_wb_dat,
  output logic                               o_wb_ack,
  input  logic                               i_m1,
  input  logic                               i_key_press,
  input  logic [6:0]                         i_kbd_code,
  input  logic                               i_hblank,
  input  logic                               i_vblank,
  output logic                               o_nmi,
  output logic [genie_map_pkg::ROM_AW-1:0]   o_rom_addr,
  input  logic [genie_map_pkg::DATA_W-1:0]   i_rom_data
);

  genie_bus_if bus ();  // decoded transfer and control state

  bus_decoder u_bus_decoder (
    .w_clk_cpu   (w_clk_cpu),
    .w_cpu_reset (w_cpu_reset),
    .i_wb_cyc    (i_wb_cyc),
    .i_wb_stb    (i_wb_stb),
    .i_wb_we     (i_wb_we),
    .i_wb_adr    (i_wb_adr),
    .i_wb_dat    (i_wb_dat),
    .o_wb_ack    (o_wb_ack),
    .bus         (bus.decoder)
  );

  io_ports u_io_ports (
    .w_clk_cpu   (w_clk_cpu),
    .w_cpu_reset (w_cpu_reset),
    .i_m1        (i_m1),
    .i_key_press (i_key_press),
    .i_kbd_code  (i_kbd_code),
    .i_hblank    (i_hblank),
    .i_vblank    (i_vblank),
    .o_nmi       (o_nmi),
    .bus         (bus.ports)
  );

  mem_map #(.RAM_AW(RAM_AW), .VRAM_AW(VRAM_AW)) u_mem_map (
    .w_clk_cpu   (w_clk_cpu),
    .bus         (bus.mem),
    .o_rom_addr  (o_rom_addr),
    .i_rom_data  (i_rom_data),
    .o_wb_dat    (o_wb_dat)
  );

endmodule

`default_nettype wire

// File: design/mem_map.sv
/*
  main, video and attribute ram, rom address remapping and the read
  data mux. ram reads are registered on req, the mux is combinational
*/
`timescale 1ns/1ps
`default_nettype none

module mem_map #(
  parameter int RAM_AW  = 16,  // main ram
  parameter int VRAM_AW = 11   // video and attribute ram
) (
  input  logic                               w_clk_cpu,
  genie_bus_if.mem                           bus,
  output logic [genie_map_pkg::ROM_AW-1:0]   o_rom_addr,
  input  logic [genie_map_pkg::DATA_W-1:0]   i_rom_data,
  output logic [genie_map_pkg::DATA_W-1:0]   o_wb_dat
);
  import genie_map_pkg::*;

  logic [DATA_W-1:0]  r_ram  [0:2**RAM_AW-1];
  logic [DATA_W-1:0]  r_vram [0:2**VRAM_AW-1];
  logic [DATA_W-1:0]  r_aram [0:2**VRAM_AW-1];
  logic [DATA_W-1:0]  r_ram_q;                  // main ram read word
  logic [DATA_W-1:0]  r_vid_q;                  // video or attribute read word
  logic [RAM_AW-1:0]  w_ram_addr;
  logic [VRAM_AW-1:0] w_vid_addr;
  logic               w_ram_we;
  logic               w_vid_we;

  // low map window 4000-7FFF folds down to 0000
  assign w_ram_addr = (!bus.high_map && bus.addr < RAM_TOP_LO) ?
                      RAM_AW'(bus.addr[13:0]) : RAM_AW'(bus.addr);
  assign w_vid_addr = VRAM_AW'(bus.addr - VRAM_LO);  // linear from F000
  assign w_ram_we   = bus.req && bus.we && bus.region == REG_RAM;
  assign w_vid_we   = bus.req && bus.we && bus.region == REG_VRAM;

  always_ff @(posedge w_clk_cpu) begin
    if (w_ram_we)
      r_ram[w_ram_addr] <= bus.wdata;
    if (w_vid_we && bus.attr_sel)
      r_aram[w_vid_addr] <= bus.wdata;
    if (w_vid_we && !bus.attr_sel)
      r_vram[w_vid_addr] <= bus.wdata;
    if (bus.req) begin
      r_ram_q <= r_ram[w_ram_addr];  // old data on a write, unused then
      r_vid_q <= bus.attr_sel ? r_aram[w_vid_addr] : r_vram[w_vid_addr];
    end
  end

  // rom remapping, only the windows classified as rom are moved
  always_comb begin
    o_rom_addr = bus.addr[ROM_AW-1:0];
    if (bus.region == REG_ROM) begin
      if (bus.addr[15:12] == ROM_A_LO[15:12])
        o_rom_addr = {1'b0, bus.addr[11:0]};                          // E000, offset 0000
      else if (bus.addr[15:12] == VRAM_LO[15:12])
        o_rom_addr = {bus.addr[12], 2'b00, bus.addr[11], bus.addr[8:0]};  // F600, 1000
      else
        o_rom_addr = {bus.addr[12], 1'b0, bus.addr[10:0]};           // 1C00, 1400
    end
  end

  always_comb begin
    case (bus.region)
      REG_RAM:  o_wb_dat = r_ram_q;
      REG_VRAM: o_wb_dat = r_vid_q;
      REG_PORT: o_wb_dat = bus.port_rdata;
      default:  o_wb_dat = i_rom_data;  // rom and unmapped
    endcase
  end

  // decoder region must agree with the raw address for any ram write
  a_ram_wr_range: assert property (@(posedge w_clk_cpu)
    (w_ram_we || w_vid_we) |->
      (w_ram_we && (bus.addr >= RAM_TOP_LO || bus.addr <= RAM_HIGH_TOP)) ||
      (w_vid_we && bus.addr >= VRAM_LO && bus.addr <= VRAM_HI));

endmodule

`default_nettype wire

// File: design/io_ports.sv
/*
  port page registers: control register, key ready flag, the fetch
  counter that raises nmi, and the read value for the port page
*/
`timescale 1ns/1ps
`default_nettype none

module io_ports (
  input  logic         w_clk_cpu,
  input  logic         w_cpu_reset,
  input  logic         i_m1,         // fetch strobe
  input  logic         i_key_press,  // one cycle pulse
  input  logic [6:0]   i_kbd_code,
  input  logic         i_hblank,
  input  logic         i_vblank,
  output logic         o_nmi,
  genie_bus_if.ports   bus
);
  import genie_map_pkg::*;
  import genie_port_pkg::*;

  logic [DATA_W-1:0]    r_ctrl;       // port FC
  logic                 r_key_ready;
  logic [NMI_CNT_W-1:0] r_nmi_cnt;
  logic                 r_m1_d;       // fetch strobe, last cycle
  logic                 w_ctrl_wr;
  logic                 w_m1_rise;

  assign w_ctrl_wr = bus.req && bus.we && bus.region == REG_PORT &&
                     bus.addr[7:0] == PORT_CTRL;
  assign w_m1_rise = i_m1 && !r_m1_d;

  always_ff @(posedge w_clk_cpu or negedge w_cpu_reset) begin
    if (!w_cpu_reset) begin
      r_ctrl      <= '0;              // low map, video ram selected
      r_key_ready <= 1'b0;
      r_nmi_cnt   <= '0;
      r_m1_d      <= 1'b0;
    end else begin
      r_m1_d <= i_m1;
      if (w_ctrl_wr)
        r_ctrl <= bus.wdata;

      // key press wins over the acknowledge
      if (i_key_press)
        r_key_ready <= 1'b1;
      else if (w_ctrl_wr && !bus.wdata[CTRL_KEY_ACK])
        r_key_ready <= 1'b0;

      if (w_ctrl_wr && bus.wdata[CTRL_NMI_CLR])
        r_nmi_cnt <= '0;
      else if (w_m1_rise && !r_ctrl[CTRL_NMI_CLR])
        r_nmi_cnt <= r_nmi_cnt + 1'b1;  // counts fetches while enabled
    end
  end

  assign o_nmi        = r_nmi_cnt[NMI_CNT_W-1];  // 8th fetch
  assign bus.high_map = r_ctrl[CTRL_HIGH_MAP];
  assign bus.attr_sel = r_ctrl[CTRL_ATTR_SEL];

  // read side, decoded from the low address byte only
  always_comb begin
    bus.port_rdata = '0;
    case (bus.addr[7:0])
      PORT_STATUS_A: bus.port_rdata = {6'b111111, ~i_hblank, ~i_vblank};
      PORT_CTRL:     bus.port_rdata = {1'b0, i_kbd_code};
      PORT_STATUS_B: begin
        bus.port_rdata[STAT_HBLANK]  = i_hblank;
        bus.port_rdata[STAT_VBLANK]  = i_vblank;
        bus.port_rdata[STAT_KEY_RDY] = r_key_ready;
      end
      default:       bus.port_rdata = '0;
    endcase
  end

  // control write only from FBxx, or from 1Bxx while the low map is active
  a_ctrl_port: assert property (@(posedge w_clk_cpu) disable iff (!w_cpu_reset)
    w_ctrl_wr |-> (bus.addr[15:8] == PORT_PAGE_HI ||
                   (bus.addr[15:8] == PORT_ALIAS_HI && !bus.high_map)));

endmodule

`default_nettype wire

// File: design/bus_decoder.sv
/*
  wishbone classic slave front end. classifies the held address into a
  region and issues the req pulse, then the single cycle ack one clock later
*/
`timescale 1ns/1ps
`default_nettype none

module bus_decoder (
  input  logic                               w_clk_cpu,
  input  logic                               w_cpu_reset,
  input  logic                               i_wb_cyc,
  input  logic                               i_wb_stb,
  input  logic                               i_wb_we,
  input  logic [genie_map_pkg::ADDR_W-1:0]   i_wb_adr,
  input  logic [genie_map_pkg::DATA_W-1:0]   i_wb_dat,
  output logic                               o_wb_ack,
  genie_bus_if.decoder                       bus
);
  import genie_map_pkg::*;
  import genie_port_pkg::*;

  logic                r_req;     // start pulse
  logic                r_busy;    // transfer served, wait for stb low
  logic                w_strobe;
  logic [REGION_W-1:0] w_region;
  logic [7:0]          w_hi;

  assign w_strobe = i_wb_cyc && i_wb_stb;
  assign w_hi     = i_wb_adr[15:8];

  always_ff @(posedge w_clk_cpu or negedge w_cpu_reset) begin
    if (!w_cpu_reset) begin
      r_req    <= 1'b0;
      r_busy   <= 1'b0;
      o_wb_ack <= 1'b0;
    end else begin
      r_req    <= w_strobe && !r_busy;  // first edge of a new transfer
      o_wb_ack <= r_req;                // ack trails req by one cycle
      if (w_strobe && !r_busy)
        r_busy <= 1'b1;
      else if (!w_strobe)
        r_busy <= 1'b0;                 // back-pressure ends when stb seen low
    end
  end

  // region order follows the hardware decode priority
  always_comb begin
    w_region = REG_DEFAULT;
    if (w_hi == PORT_PAGE_HI || (w_hi == PORT_ALIAS_HI && !bus.high_map))
      w_region = REG_PORT;
    else if (i_wb_adr >= VRAM_LO && i_wb_adr <= VRAM_HI)
      w_region = REG_VRAM;
    else if (i_wb_adr >= ROM_A_LO && i_wb_adr < VRAM_LO)
      w_region = REG_ROM;
    else if (i_wb_adr >= ROM_B_LO && i_wb_adr <= ROM_B_HI)
      w_region = REG_ROM;
    else if (i_wb_adr >= RAM_TOP_LO)
      w_region = REG_RAM;
    else if (!bus.high_map) begin
      if (i_wb_adr >= RAM_LOW_LO && i_wb_adr <= RAM_LOW_HI)
        w_region = REG_RAM;                      // 16k window, folded down
      else if (i_wb_adr[15:9] == ROM_C_LO[15:9])
        w_region = REG_ROM;                      // 1C00-1DFF
    end else if (i_wb_adr <= RAM_HIGH_TOP)
      w_region = REG_RAM;                        // high map, ram from 0000
  end

  assign bus.req    = r_req;
  assign bus.we     = i_wb_we;
  assign bus.addr   = i_wb_adr;
  assign bus.wdata  = i_wb_dat;
  assign bus.region = w_region;

  a_ack_single: assert property (@(posedge w_clk_cpu) disable iff (!w_cpu_reset)
    o_wb_ack |=> !o_wb_ack);
  a_req_cyc: assert property (@(posedge w_clk_cpu) disable iff (!w_cpu_reset)
    bus.req |-> i_wb_cyc);

endmodule

`default_nettype wire

// File: design/genie_bus_if.sv
/*
  decoded cpu transfer plus the control state that steers decoding,
  shared by the decoder, the port block and the memory block
*/
`timescale 1ns/1ps
`default_nettype none

interface genie_bus_if;
  import genie_map_pkg::*;

  logic                req;         // one cycle, start of transfer
  logic                we;
  logic [ADDR_W-1:0]   addr;        // held by master until ack
  logic [DATA_W-1:0]   wdata;
  logic [REGION_W-1:0] region;
  logic [DATA_W-1:0]   port_rdata;  // port page read value
  logic                high_map;    // control bit 7
  logic                attr_sel;    // control bit 6

  modport decoder (output req, we, addr, wdata, region, input high_map);
  modport ports (
    input  req, we, addr, wdata, region,
    output port_rdata, high_map, attr_sel
  );
  modport mem (input req, we, addr, wdata, region, port_rdata, high_map, attr_sel);

endinterface

`default_nettype wire

// File: design/genie_port_pkg.sv
/*
  layout of the memory mapped port page: page bases, register offsets,
  control register bits and status bit positions
*/
`default_nettype none

package genie_port_pkg;

  localparam logic [7:0] PORT_PAGE_HI  = 8'hFB;  // always mapped
  localparam logic [7:0] PORT_ALIAS_HI = 8'h1B;  // alias while low map active

  localparam logic [7:0] PORT_STATUS_A = 8'h00;  // inverted blanking
  localparam logic [7:0] PORT_CTRL     = 8'hFC;  // control write, key code read
  localparam logic [7:0] PORT_STATUS_B = 8'hFE;  // blanking and key ready

  // control register bits
  localparam int CTRL_KEY_ACK  = 0;  // low on write clears key ready
  localparam int CTRL_NMI_CLR  = 1;  // high clears and holds nmi counter
  localparam int CTRL_ATTR_SEL = 6;  // video window goes to attribute ram
  localparam int CTRL_HIGH_MAP = 7;  // ram from 0000, alias and low window off

  // status register B bits
  localparam int STAT_HBLANK  = 7;
  localparam int STAT_VBLANK  = 6;
  localparam int STAT_KEY_RDY = 0;

  localparam int NMI_CNT_W = 4;  // msb is the nmi line

endpackage

`default_nettype wire

// File: design/genie_map_pkg.sv
/*
  memory map of the processor side: bus widths, region codes and the
  address boundaries used by the decoder and the RAM/ROM block
*/
`default_nettype none

package genie_map_pkg;

  localparam int DATA_W = 8;   // cpu data bus
  localparam int ADDR_W = 16;  // cpu address bus
  localparam int ROM_AW = 13;  // external rom, 8k words

  // classification of one transfer
  localparam int REGION_W = 3;
  localparam logic [REGION_W-1:0] REG_PORT    = 3'd0;  // control port page
  localparam logic [REGION_W-1:0] REG_VRAM    = 3'd1;  // video or attribute ram
  localparam logic [REGION_W-1:0] REG_ROM     = 3'd2;  // remapped rom windows
  localparam logic [REGION_W-1:0] REG_RAM     = 3'd3;  // main ram
  localparam logic [REGION_W-1:0] REG_DEFAULT = 3'd4;  // anything else, reads rom

  // video window
  localparam logic [ADDR_W-1:0] VRAM_LO = 16'hF000;
  localparam logic [ADDR_W-1:0] VRAM_HI = 16'hF5FF;

  // rom windows outside the plain low 8k
  localparam logic [ADDR_W-1:0] ROM_A_LO = 16'hE000;  // E000-EFFF, rom offset 0000
  localparam logic [ADDR_W-1:0] ROM_B_LO = 16'hF600;  // rom offset 1000
  localparam logic [ADDR_W-1:0] ROM_B_HI = 16'hF9FF;
  localparam logic [ADDR_W-1:0] ROM_C_LO = 16'h1C00;  // 1C00-1DFF, low map only, offset 1400

  // main ram windows
  localparam logic [ADDR_W-1:0] RAM_TOP_LO   = 16'hFC00;  // always ram up to FFFF
  localparam logic [ADDR_W-1:0] RAM_LOW_LO   = 16'h4000;  // low map window
  localparam logic [ADDR_W-1:0] RAM_LOW_HI   = 16'h7FFF;
  localparam logic [ADDR_W-1:0] RAM_HIGH_TOP = 16'hDFFF;  // high map, 0000 up to here

endpackage

`default_nettype wire
